// ==== verilog/demosaic_defines.svh ====
`ifndef DEMOSAIC_DEFINES_SVH
`define DEMOSAIC_DEFINES_SVH

// Raw sample and colour channel width
`define DEMOSAIC_PIXEL_WIDTH 10

// Line buffer depth, widest row accepted
`define DEMOSAIC_MAX_COLS 64

// Must cover DEMOSAIC_MAX_COLS-1
`define DEMOSAIC_COL_WIDTH 6

`endif

// ==== verilog/demosaic_pkg.sv ====
package demosaic_pkg;

   typedef enum logic [2:0] {
      dtype_frame_start = 3'd0,
      dtype_row_start   = 3'd1,
      dtype_pixel       = 3'd2,
      dtype_row_end     = 3'd3,
      dtype_frame_end   = 3'd4
   } dtype_t;

   // Encoded as {row phase, column phase}
   typedef enum logic [1:0] {
      site_r  = 2'd0,
      site_g1 = 2'd1,
      site_g2 = 2'd2,
      site_b  = 2'd3
   } cfa_site_t;

   typedef enum logic [1:0] {
      seq_idle  = 2'd0,
      seq_frame = 2'd1,
      seq_row   = 2'd2
   } seq_state_t;

endpackage

// ==== verilog/column_counter.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module column_counter import demosaic_pkg::*; (
   input  logic                           clk,
   input  logic                           resetb,
   input  logic                           dvi,
   input  logic                           enable,
   input  dtype_t                         dtypei,
   output logic [`DEMOSAIC_COL_WIDTH-1:0] col,
   output logic                           row_ge2,
   output logic                           col_ge2
);

   logic                           accept;
   logic [`DEMOSAIC_COL_WIDTH-1:0] col_next;
   logic [1:0]                     row_cnt;   // Saturates at 2

   assign accept   = dvi & enable;
   assign col_next = col + 1'b1;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col     <= '0;
         row_cnt <= 2'd0;
         row_ge2 <= 1'b0;
         col_ge2 <= 1'b0;
      end else if (accept) begin
         case (dtypei)
            dtype_frame_start: begin
               row_cnt <= 2'd0;
               row_ge2 <= 1'b0;
            end
            dtype_row_start: begin
               col     <= '0;
               col_ge2 <= 1'b0;
            end
            dtype_pixel: begin
               col     <= col_next;
               col_ge2 <= (col_next >= 2);
            end
            dtype_row_end: begin
               if (row_cnt != 2'd2) row_cnt <= row_cnt + 2'd1;
               row_ge2 <= (row_cnt >= 2'd1);   // Value after this row end
            end
            default: ;
         endcase
      end
   end

endmodule

// ==== verilog/kernel.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module kernel import demosaic_pkg::*; (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             dvi,
   input  logic                             enable,
   input  dtype_t                           dtypei,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] datai,
   input  logic [`DEMOSAIC_COL_WIDTH-1:0]   col,
   input  logic                             row_ge2,
   input  logic                             col_ge2,
   output logic                             kdv,
   output dtype_t                           kdtype,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k00,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k01,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k02,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k10,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k11,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k12,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k20,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k21,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k22
);

   // line_new holds the previous row, line_old the one above it
   logic [`DEMOSAIC_PIXEL_WIDTH-1:0] line_new [0:`DEMOSAIC_MAX_COLS-1];
   logic [`DEMOSAIC_PIXEL_WIDTH-1:0] line_old [0:`DEMOSAIC_MAX_COLS-1];
   logic [`DEMOSAIC_PIXEL_WIDTH-1:0] top_px;
   logic [`DEMOSAIC_PIXEL_WIDTH-1:0] mid_px;
   logic                             accept;
   logic                             pix;
   logic                             fwd;

   assign accept = dvi & enable;
   assign pix    = accept && (dtypei == dtype_pixel);
   assign top_px = line_old[col];
   assign mid_px = line_new[col];

   // Border drop
   always_comb begin
      case (dtypei)
         dtype_pixel:     fwd = row_ge2 & col_ge2;
         dtype_row_start: fwd = row_ge2;
         dtype_row_end:   fwd = row_ge2;
         default:         fwd = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (pix) begin
         line_new[col] <= datai;
         line_old[col] <= mid_px;   // Row ages by one
      end
   end

   // Newest column enters on the right
   always_ff @(posedge clk) begin
      if (pix) begin
         k00 <= k01;
         k01 <= k02;
         k02 <= top_px;
         k10 <= k11;
         k11 <= k12;
         k12 <= mid_px;
         k20 <= k21;
         k21 <= k22;
         k22 <= datai;
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         kdv    <= 1'b0;
         kdtype <= dtype_frame_start;
      end else begin
         kdv <= accept & fwd;
         if (accept) begin
            kdtype <= dtypei;
         end
      end
   end

endmodule

// ==== verilog/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer import demosaic_pkg::*; (
   input  logic      clk,
   input  logic      resetb,
   input  logic      kdv,
   input  dtype_t    kdtype,
   input  logic [1:0] phase,
   output cfa_site_t site
);

   seq_state_t state;
   logic       row_phase;
   logic       col_phase;

   // Valid in the same cycle as the pixel
   assign site = cfa_site_t'({row_phase, col_phase});

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         state     <= seq_idle;
         row_phase <= 1'b0;
         col_phase <= 1'b0;
      end else if (kdv) begin
         case (kdtype)
            dtype_frame_start: begin
               state     <= seq_frame;
               row_phase <= phase[1];
            end
            dtype_row_start: begin
               if (state != seq_idle) begin
                  state     <= seq_row;
                  col_phase <= phase[0];
               end
            end
            dtype_pixel: begin
               if (state == seq_row) col_phase <= ~col_phase;
            end
            dtype_row_end: begin
               if (state == seq_row) begin
                  state     <= seq_frame;
                  row_phase <= ~row_phase;
               end
            end
            dtype_frame_end: begin
               state <= seq_idle;
            end
            default: ;
         endcase
      end
   end

endmodule

// ==== verilog/interp_ed.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module interp_ed import demosaic_pkg::*; (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             kdv,
   input  dtype_t                           kdtype,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k00,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k01,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k02,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k10,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k11,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k12,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k20,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k21,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k22,
   input  cfa_site_t                        site,
   output logic                             dvo,
   output dtype_t                           dtypeo,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] r,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] g,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] b
);

   localparam int PW = `DEMOSAIC_PIXEL_WIDTH;

   // Rounded mean of two samples
   function automatic logic [PW-1:0] avg2(input logic [PW-1:0] x0, input logic [PW-1:0] x1);
      logic [PW:0] sum;
      sum = {1'b0, x0} + {1'b0, x1} + 1'b1;
      return sum[PW:1];
   endfunction

   function automatic logic [PW-1:0] absdiff(input logic [PW-1:0] x0, input logic [PW-1:0] x1);
      return (x0 > x1) ? x0 - x1 : x1 - x0;
   endfunction

   logic [PW-1:0] kvert, khorz, kdiag, kanti;
   logic [PW-1:0] dvert, dhorz, ddiag, danti;
   logic [PW-1:0] kplus, kdiamond;

   assign kvert = avg2(k01, k21);
   assign khorz = avg2(k10, k12);
   assign kdiag = avg2(k00, k22);
   assign kanti = avg2(k20, k02);
   assign dvert = absdiff(k01, k21);
   assign dhorz = absdiff(k10, k12);
   assign ddiag = absdiff(k00, k22);
   assign danti = absdiff(k20, k02);

   // Smaller gradient wins, ties go to vertical and main diagonal
   assign kplus    = (dvert > dhorz) ? khorz : kvert;
   assign kdiamond = (ddiag > danti) ? kanti : kdiag;

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo    <= 1'b0;
         dtypeo <= dtype_frame_start;
         r      <= '0;
         g      <= '0;
         b      <= '0;
      end else begin
         dvo    <= kdv;
         dtypeo <= kdtype;
         if (kdv && kdtype == dtype_pixel) begin
            case (site)
               site_r: begin
                  r <= k11;
                  g <= kplus;
                  b <= kdiamond;
               end
               site_g1: begin
                  r <= khorz;   // Red neighbours left and right
                  g <= k11;
                  b <= kvert;
               end
               site_g2: begin
                  r <= kvert;
                  g <= k11;
                  b <= khorz;
               end
               default: begin
                  r <= kdiamond;
                  g <= kplus;
                  b <= k11;
               end
            endcase
         end
      end
   end

endmodule

// ==== verilog/demosaic_top.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module demosaic_top import demosaic_pkg::*; (
   input  logic                             clk,
   input  logic                             resetb,
   input  logic                             enable,
   input  logic                             dvi,
   input  dtype_t                           dtypei,
   input  logic [`DEMOSAIC_PIXEL_WIDTH-1:0] datai,
   input  logic [1:0]                       phase,
   output logic                             dvo,
   output dtype_t                           dtypeo,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] r,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] g,
   output logic [`DEMOSAIC_PIXEL_WIDTH-1:0] b
);

   logic [`DEMOSAIC_COL_WIDTH-1:0]   col;
   logic                             row_ge2, col_ge2;
   logic                             kdv;
   dtype_t                           kdtype;
   logic [`DEMOSAIC_PIXEL_WIDTH-1:0] k00, k01, k02, k10, k11, k12, k20, k21, k22;
   cfa_site_t                        site;

   column_counter column_counter_i (
      .clk(clk), .resetb(resetb), .dvi(dvi), .enable(enable), .dtypei(dtypei),
      .col(col), .row_ge2(row_ge2), .col_ge2(col_ge2)
   );

   kernel kernel_i (
      .clk(clk), .resetb(resetb), .dvi(dvi), .enable(enable), .dtypei(dtypei),
      .datai(datai), .col(col), .row_ge2(row_ge2), .col_ge2(col_ge2),
      .kdv(kdv), .kdtype(kdtype),
      .k00(k00), .k01(k01), .k02(k02), .k10(k10), .k11(k11), .k12(k12),
      .k20(k20), .k21(k21), .k22(k22)
   );

   frame_sequencer frame_sequencer_i (
      .clk(clk), .resetb(resetb), .kdv(kdv), .kdtype(kdtype), .phase(phase), .site(site)
   );

   interp_ed interp_ed_i (
      .clk(clk), .resetb(resetb), .kdv(kdv), .kdtype(kdtype),
      .k00(k00), .k01(k01), .k02(k02), .k10(k10), .k11(k11), .k12(k12),
      .k20(k20), .k21(k21), .k22(k22), .site(site),
      .dvo(dvo), .dtypeo(dtypeo), .r(r), .g(g), .b(b)
   );

endmodule

// ==== tests/demosaic_chk.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module demosaic_chk import demosaic_pkg::*; (
   input logic                             clk,
   input logic                             resetb,
   input logic                             enable,
   input logic                             dvi,
   input dtype_t                           dtypei,
   input logic                             dvo,
   input dtype_t                           dtypeo,
   input logic [`DEMOSAIC_PIXEL_WIDTH-1:0] r,
   input logic [`DEMOSAIC_PIXEL_WIDTH-1:0] g,
   input logic [`DEMOSAIC_PIXEL_WIDTH-1:0] b
);

   logic       accept;
   logic [1:0] rows_seen;   // Completed input rows, saturates at 2
   logic [1:0] cols_seen;   // Pixels so far in this row, saturates at 2
   logic       inner_px;    // Accepted pixel inside the border

   assign accept   = dvi && enable;
   assign inner_px = accept && (dtypei == dtype_pixel) &&
                     (rows_seen == 2'd2) && (cols_seen == 2'd2);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rows_seen <= 2'd0;
         cols_seen <= 2'd0;
      end else if (accept) begin
         case (dtypei)
            dtype_frame_start: rows_seen <= 2'd0;
            dtype_row_start:   cols_seen <= 2'd0;
            dtype_pixel: begin
               if (cols_seen != 2'd2) cols_seen <= cols_seen + 2'd1;
            end
            dtype_row_end: begin
               if (rows_seen != 2'd2) rows_seen <= rows_seen + 2'd1;
            end
            default: ;
         endcase
      end
   end

   reset_quiet: assert property (@(negedge clk)
      !resetb |-> (!dvo && r == '0 && g == '0 && b == '0))
      else $error("outputs not zero during reset");

   dtype_valid: assert property (@(posedge clk) disable iff (!resetb)
      dvo |-> (dtypeo inside {dtype_frame_start, dtype_row_start, dtype_pixel,
                              dtype_row_end, dtype_frame_end}))
      else $error("dtypeo holds no valid token type while dvo is high");

   // Two register stages from input to output
   pixel_latency: assert property (@(posedge clk) disable iff (!resetb)
      $past(inner_px, 2) |-> (dvo && dtypeo == dtype_pixel))
      else $error("pixel did not appear on dvo two cycles after acceptance");

endmodule

bind demosaic_top demosaic_chk demosaic_chk_i (
   .clk(clk), .resetb(resetb), .enable(enable), .dvi(dvi), .dtypei(dtypei),
   .dvo(dvo), .dtypeo(dtypeo), .r(r), .g(g), .b(b)
);

// ==== tests/demosaic_tb.sv ====
`timescale 1ns/1ps
`include "demosaic_defines.svh"

module demosaic_tb import demosaic_pkg::*; #(
   parameter int SEED = 32'h9c82
);

   localparam int PW = `DEMOSAIC_PIXEL_WIDTH;
   localparam int W = 8;
   localparam int H = 6;
   localparam int OUT_TOKENS = (W - 2) * (H - 2) + 2 * (H - 2) + 2;
   localparam int NUM_FRAMES = 10;
   // Idle gaps add at most two cycles per token
   localparam int TIMEOUT_CYCLES = NUM_FRAMES * (2 + H * (W + 2)) * 3 + 500;

   logic          clk, resetb, enable, dvi, dvo;
   dtype_t        dtypei, dtypeo;
   logic [PW-1:0] datai, r, g, b;
   logic [1:0]    phase;
   logic [PW-1:0] img [0:H-1][0:W-1];
   dtype_t        exp_type[$], got_type[$];
   logic [PW-1:0] exp_r[$], exp_g[$], exp_b[$], got_r[$], got_g[$], got_b[$];
   integer        seed;
   int            cycles = 0;

   demosaic_top demosaic_top_i (
      .clk(clk), .resetb(resetb), .enable(enable), .dvi(dvi), .dtypei(dtypei),
      .datai(datai), .phase(phase), .dvo(dvo), .dtypeo(dtypeo), .r(r), .g(g), .b(b)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, output tokens never completed", cycles);
         $display("=== FAIL ===");
         $fatal(1, "simulation timeout");
      end
   end

   always @(negedge clk) begin   // Output monitor
      if (resetb && dvo) begin
         got_type.push_back(dtypeo);
         got_r.push_back(r);
         got_g.push_back(g);
         got_b.push_back(b);
      end
   end

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   function automatic int mean_round(input int x0, input int x1);
      return (x0 + x1 + 1) / 2;
   endfunction

   function automatic int abs_gap(input int x0, input int x1);
      return (x0 > x1) ? x0 - x1 : x1 - x0;
   endfunction

   task automatic expect_token(input dtype_t t, input int er, input int eg, input int eb);
      exp_type.push_back(t);
      exp_r.push_back(er[PW-1:0]);
      exp_g.push_back(eg[PW-1:0]);
      exp_b.push_back(eb[PW-1:0]);
   endtask

   // Reference demosaic of img, output pixel centred on input (i, j)
   task automatic build_expected(input logic [1:0] ph);
      int         vert, horz, diag, anti, plus, diamond, c;
      logic [1:0] site_bits;
      expect_token(dtype_frame_start, 0, 0, 0);
      for (int i = 1; i < H - 1; i++) begin
         expect_token(dtype_row_start, 0, 0, 0);
         for (int j = 1; j < W - 1; j++) begin
            c    = img[i][j];
            vert = mean_round(img[i-1][j], img[i+1][j]);
            horz = mean_round(img[i][j-1], img[i][j+1]);
            diag = mean_round(img[i-1][j-1], img[i+1][j+1]);
            anti = mean_round(img[i+1][j-1], img[i-1][j+1]);
            plus = (abs_gap(img[i-1][j], img[i+1][j]) <= abs_gap(img[i][j-1], img[i][j+1]))
                   ? vert : horz;
            diamond = (abs_gap(img[i-1][j-1], img[i+1][j+1]) <=
                       abs_gap(img[i+1][j-1], img[i-1][j+1])) ? diag : anti;
            site_bits = ph ^ {(i % 2 == 0), (j % 2 == 0)};   // First output at i=1, j=1
            case (site_bits)
               site_r:  expect_token(dtype_pixel, c, plus, diamond);
               site_g1: expect_token(dtype_pixel, horz, c, vert);
               site_g2: expect_token(dtype_pixel, vert, c, horz);
               default: expect_token(dtype_pixel, diamond, plus, c);
            endcase
         end
         expect_token(dtype_row_end, 0, 0, 0);
      end
      expect_token(dtype_frame_end, 0, 0, 0);
   endtask

   task automatic send_token(input dtype_t t, input logic [PW-1:0] d, input bit gaps);
      int idle;
      idle = gaps ? $unsigned($random(seed)) % 3 : 0;
      repeat (idle) begin
         @(negedge clk);
         dvi = 1'b0;
      end
      @(negedge clk);
      dvi    = 1'b1;
      dtypei = t;
      datai  = d;
   endtask

   task automatic send_frame(input bit gaps);
      send_token(dtype_frame_start, '0, gaps);
      for (int i = 0; i < H; i++) begin
         send_token(dtype_row_start, '0, gaps);
         for (int j = 0; j < W; j++)
            send_token(dtype_pixel, img[i][j], gaps);
         send_token(dtype_row_end, '0, gaps);
      end
      send_token(dtype_frame_end, '0, gaps);
      @(negedge clk);
      dvi = 1'b0;
   endtask

   task automatic fill_image(input int base, input int span);
      for (int i = 0; i < H; i++)
         for (int j = 0; j < W; j++)
            img[i][j] = base + (span > 1 ? $unsigned($random(seed)) % span : 0);
   endtask

   task automatic collect(input int n);
      while (got_type.size() < n)
         @(negedge clk);
      repeat (4) @(negedge clk);   // Catch extra tokens
      check_value("dvo token count", got_type.size(), n);
   endtask

   task automatic compare_tokens();
      dtype_t        et;
      logic [PW-1:0] er, eg, eb, gr, gg, gb;
      while (exp_type.size() > 0) begin
         et = exp_type.pop_front();
         er = exp_r.pop_front();
         eg = exp_g.pop_front();
         eb = exp_b.pop_front();
         gr = got_r.pop_front();
         gg = got_g.pop_front();
         gb = got_b.pop_front();
         check_value("dtypeo", got_type.pop_front(), et);
         if (et == dtype_pixel) begin
            check_value("r", gr, er);
            check_value("g", gg, eg);
            check_value("b", gb, eb);
         end
      end
   endtask

   task automatic run_frame(input logic [1:0] ph, input bit gaps);
      phase = ph;
      build_expected(ph);
      send_frame(gaps);
      collect(exp_type.size());
      compare_tokens();
   endtask

   task automatic test_flat_field();
      dtype_t t;
      fill_image(10'h2a5, 0);
      phase = 2'd0;
      send_frame(1'b0);
      collect(OUT_TOKENS);
      while (got_type.size() > 0) begin
         t = got_type.pop_front();
         if (t == dtype_pixel) begin
            check_value("r", got_r[0], 10'h2a5);
            check_value("g", got_g[0], 10'h2a5);
            check_value("b", got_b[0], 10'h2a5);
         end
         void'(got_r.pop_front());
         void'(got_g.pop_front());
         void'(got_b.pop_front());
      end
   endtask

   task automatic test_token_structure();
      phase = 2'd0;
      fill_image(0, 1 << PW);
      send_frame(1'b0);
      collect(OUT_TOKENS);
      check_value("dtypeo", got_type.pop_front(), dtype_frame_start);
      for (int i = 0; i < H - 2; i++) begin
         check_value("dtypeo", got_type.pop_front(), dtype_row_start);
         for (int j = 0; j < W - 2; j++)
            check_value("dtypeo", got_type.pop_front(), dtype_pixel);
         check_value("dtypeo", got_type.pop_front(), dtype_row_end);
      end
      check_value("dtypeo", got_type.pop_front(), dtype_frame_end);
      got_r.delete();
      got_g.delete();
      got_b.delete();
   endtask

   task automatic test_random_phases();
      fill_image(0, 1 << PW);
      for (int ph = 0; ph < 4; ph++)
         run_frame(ph[1:0], 1'b0);
      fill_image(10'h1f0, 3);   // Narrow range forces gradient ties
      run_frame(2'd0, 1'b0);
   endtask

   task automatic test_enable_low();
      enable = 1'b0;
      send_frame(1'b0);
      repeat (8) @(negedge clk);
      check_value("dvo token count", got_type.size(), 0);
      enable = 1'b1;
      run_frame(2'd1, 1'b0);
   endtask

   task automatic test_idle_gaps();
      fill_image(0, 1 << PW);
      run_frame(2'd2, 1'b1);
   endtask

   initial begin
      clk    = 1'b0;
      resetb = 1'b0;
      enable = 1'b1;
      dvi    = 1'b0;
      dtypei = dtype_frame_start;
      datai  = '0;
      phase  = 2'd0;
      seed   = SEED;
      repeat (4) @(posedge clk);
      @(negedge clk);
      resetb = 1'b1;
      test_flat_field();
      test_token_structure();
      test_random_phases();
      test_enable_low();
      test_idle_gaps();
      if (got_type.size() != 0) begin
         $display("Output tokens left over after the last test");
         $display("=== FAIL ===");
         $fatal(1, "leftover output tokens");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/demosaic_pkg.sv
verilog/column_counter.sv
verilog/kernel.sv
verilog/frame_sequencer.sv
verilog/interp_ed.sv
verilog/demosaic_top.sv
tests/demosaic_chk.sv
tests/demosaic_tb.sv

// ==== Makefile ====
# Verilator build and run for the demosaic testbench

VERILATOR ?= verilator
TOP       ?= demosaic_tb
SEED      ?= 40066
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --assert -Wno-fatal

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) verilog/demosaic_defines.svh

.PHONY: all build run check clean

all: check

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@grep -q "^=== PASS ===$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
